// ==== acc_cmd_pkg.sv ====
/*
  Wire protocol of the command engine: bus word, header layouts and codes.
  Shared by the decoder, result merge, top level and testbench.
*/
package acc_cmd_pkg;

  typedef logic [63:0] word_t; // One receive or transmit bus word

  // Command codes carried in the top byte of a header
  typedef enum logic [7:0] {
    CMD_STATUS  = 8'h01, // Version and command counter query
    CMD_USR_RST = 8'h02, // User reset pulse, no reply
    CMD_FOLD    = 8'h10, // Sum of payload halves against target
    CMD_MASK    = 8'h20  // Set-bit count against threshold
  } cmd_e;

  // Reply codes, top bit set so replies never look like commands
  typedef enum logic [7:0] {
    RPL_STATUS = 8'h81,
    RPL_FOLD   = 8'h90,
    RPL_MASK   = 8'hA0,
    RPL_ERR    = 8'hFF
  } rpl_e;

  typedef enum logic [7:0] {
    STS_OK        = 8'h00,
    STS_FAIL      = 8'h01, // Check ran but did not match
    STS_BAD_CMD   = 8'h10,
    STS_BAD_LEN   = 8'h11,
    STS_BAD_FRAME = 8'h12  // sop/eop placement broken inside payload
  } sts_e;

  // Header as sent by the host
  typedef struct packed {
    cmd_e        cmd;
    logic [7:0]  len; // Payload word count
    logic [15:0] tag; // Echoed in the reply
    logic [31:0] arg; // Target or threshold
  } cmd_hdr_t;

  // Header as returned to the host
  typedef struct packed {
    rpl_e        rpl;
    sts_e        sts;
    logic [15:0] tag;
    logic [31:0] data;
  } rpl_hdr_t;

  // Same 64 bits, read one way on receive and written the other on transmit
  typedef union packed {
    cmd_hdr_t cmd_hdr;
    rpl_hdr_t rpl_hdr;
  } hdr_word_u;

  localparam logic [15:0] VERSION = 16'h0102; // Upper half of status data

endpackage

// ==== acc_core_pkg.sv ====
/*
  Internal types passed between the decode, execute and result stages,
  plus the execute latency that result merge aligns against.
*/
package acc_core_pkg;

  // Which checking engine a payload job is meant for
  typedef enum logic {
    ENG_FOLD = 1'b0,
    ENG_MASK = 1'b1
  } eng_sel_e;

  // One payload word broadcast to both engines
  typedef struct packed {
    logic               val;   // Word strobe
    eng_sel_e           sel;   // Target engine
    logic               first; // First payload word of frame
    logic               last;  // Last payload word of frame
    acc_cmd_pkg::word_t dat;
    logic [31:0]        arg;   // Target or threshold from header
    logic [15:0]        tag;
  } job_word_t;

  // One reply request, direct from decode or from an engine
  typedef struct packed {
    logic              val;
    acc_cmd_pkg::rpl_e rpl;
    acc_cmd_pkg::sts_e sts;
    logic [15:0]       tag;
    logic [31:0]       data;
  } rpl_req_t;

  // Job word in to result out, both engines
  localparam int EXEC_LAT = 2;

endpackage

// ==== acc_engine.f ====
acc_cmd_pkg.sv
acc_core_pkg.sv
cmd_decode.sv
fold_check_exec.sv
mask_count_exec.sv
result_merge.sv
acc_engine_top.sv
tb_acc_engine.sv

// ==== acc_engine_top.sv ====
/*
  Command engine top level. Receive words go through decode, the fold
  and mask engines, and result merge onto the transmit port.
*/
module acc_engine_top (
  input  logic                   i_clk_100,
  input  logic                   i_rst_n,
  input  logic                   i_rx_val,
  input  logic                   i_rx_sop,
  input  logic                   i_rx_eop,
  input  acc_cmd_pkg::word_t     i_rx_dat,
  output logic                   o_tx_val,
  output acc_cmd_pkg::hdr_word_u o_tx_dat,
  output logic                   o_usr_rst
);

  acc_core_pkg::job_word_t job;      // Broadcast to both engines
  acc_core_pkg::rpl_req_t  dir;      // Status and error replies
  acc_core_pkg::rpl_req_t  fold_res;
  acc_core_pkg::rpl_req_t  mask_res;

  cmd_decode u_decode (
    .i_clk_100 (i_clk_100),
    .i_rst_n   (i_rst_n),
    .i_rx_val  (i_rx_val),
    .i_rx_sop  (i_rx_sop),
    .i_rx_eop  (i_rx_eop),
    .i_rx_dat  (i_rx_dat),
    .o_job     (job),
    .o_dir     (dir),
    .o_usr_rst (o_usr_rst)
  );

  fold_check_exec u_fold (
    .i_clk_100 (i_clk_100),
    .i_rst_n   (i_rst_n),
    .i_job     (job),
    .o_res     (fold_res)
  );

  mask_count_exec u_mask (
    .i_clk_100 (i_clk_100),
    .i_rst_n   (i_rst_n),
    .i_job     (job),
    .o_res     (mask_res)
  );

  result_merge u_merge (
    .i_clk_100 (i_clk_100),
    .i_rst_n   (i_rst_n),
    .i_dir     (dir),
    .i_fold    (fold_res),
    .i_mask    (mask_res),
    .o_tx_val  (o_tx_val),
    .o_tx_dat  (o_tx_dat)
  );

endmodule

// ==== cmd_decode.sv ====
/*
  Frame parser. Registers the receive word, checks header and length,
  then emits payload jobs to the engines or direct replies to result merge.
*/
module cmd_decode (
  input  logic                   i_clk_100,
  input  logic                   i_rst_n,
  input  logic                   i_rx_val,
  input  logic                   i_rx_sop,
  input  logic                   i_rx_eop,
  input  acc_cmd_pkg::word_t     i_rx_dat,
  output acc_core_pkg::job_word_t o_job,
  output acc_core_pkg::rpl_req_t  o_dir,
  output logic                   o_usr_rst
);

  typedef enum logic [1:0] {
    ST_IDLE, // Waiting for a header
    ST_PAY,  // Counting payload words
    ST_DISC  // Dropping words until eop
  } state_e;

  state_e                  state, state_nxt;
  logic                    rx_val, rx_sop, rx_eop;
  acc_cmd_pkg::word_t      rx_dat;
  acc_cmd_pkg::hdr_word_u  hdr;
  acc_core_pkg::eng_sel_e  sel;
  logic [7:0]              len, wcnt, wcnt_nxt, wcnt_inc;
  logic [15:0]             tag, ccnt, ccnt_nxt;
  logic [31:0]             arg;
  logic                    hdr_ld, rst_nxt;
  acc_core_pkg::job_word_t job_nxt;
  acc_core_pkg::rpl_req_t  dir_nxt;

  assign hdr      = rx_dat;         // Header view of the registered word
  assign wcnt_inc = wcnt + 8'd1;

  always_comb begin
    state_nxt     = state;
    wcnt_nxt      = wcnt;
    ccnt_nxt      = ccnt;
    hdr_ld        = 1'b0;
    rst_nxt       = 1'b0;
    job_nxt       = '0;
    job_nxt.sel   = sel;
    job_nxt.first = (wcnt == 8'd0);
    job_nxt.last  = (wcnt_inc == len);
    job_nxt.dat   = rx_dat;
    job_nxt.arg   = arg;
    job_nxt.tag   = tag;
    dir_nxt       = '0;
    dir_nxt.rpl   = acc_cmd_pkg::RPL_ERR; // Errors carry data 0
    dir_nxt.tag   = (state == ST_IDLE) ? hdr.cmd_hdr.tag : tag;
    if (rx_val) begin
      case (state)
        ST_IDLE: if (rx_sop) begin      // Non-sop words while idle are dropped
          case (hdr.cmd_hdr.cmd)
            acc_cmd_pkg::CMD_STATUS: begin
              dir_nxt.val = 1'b1;
              if (rx_eop) begin
                dir_nxt.rpl  = acc_cmd_pkg::RPL_STATUS;
                dir_nxt.sts  = acc_cmd_pkg::STS_OK;
                dir_nxt.data = {acc_cmd_pkg::VERSION, ccnt}; // Count before this one
                ccnt_nxt     = ccnt + 16'd1;
              end else begin
                dir_nxt.sts = acc_cmd_pkg::STS_BAD_FRAME;
                state_nxt   = ST_DISC;
              end
            end
            acc_cmd_pkg::CMD_USR_RST: begin
              if (rx_eop) begin
                rst_nxt  = 1'b1; // Silent, no reply
                ccnt_nxt = '0;
              end else begin
                dir_nxt.val = 1'b1;
                dir_nxt.sts = acc_cmd_pkg::STS_BAD_FRAME;
                state_nxt   = ST_DISC;
              end
            end
            acc_cmd_pkg::CMD_FOLD, acc_cmd_pkg::CMD_MASK: begin
              if (hdr.cmd_hdr.len == 8'd0 || rx_eop) begin
                dir_nxt.val = 1'b1;
                dir_nxt.sts = acc_cmd_pkg::STS_BAD_LEN;
                if (!rx_eop) state_nxt = ST_DISC;
              end else begin
                hdr_ld    = 1'b1;
                wcnt_nxt  = 8'd0;
                state_nxt = ST_PAY;
              end
            end
            default: begin
              dir_nxt.val = 1'b1;
              dir_nxt.sts = acc_cmd_pkg::STS_BAD_CMD;
              if (!rx_eop) state_nxt = ST_DISC;
            end
          endcase
        end
        ST_PAY: begin
          // Early eop, or len-th word without eop
          if (rx_eop != job_nxt.last) begin
            dir_nxt.val = 1'b1;
            dir_nxt.sts = acc_cmd_pkg::STS_BAD_FRAME;
            state_nxt   = rx_eop ? ST_IDLE : ST_DISC;
          end else begin
            job_nxt.val = 1'b1;
            wcnt_nxt    = wcnt_inc;
            if (rx_eop) begin
              ccnt_nxt  = ccnt + 16'd1; // Well-formed payload command done
              state_nxt = ST_IDLE;
            end
          end
        end
        ST_DISC: if (rx_eop) state_nxt = ST_IDLE;
        default: state_nxt = ST_IDLE;
      endcase
    end
  end

  // Input word and latched header fields
  always_ff @(posedge i_clk_100) begin
    rx_sop <= i_rx_sop;
    rx_eop <= i_rx_eop;
    rx_dat <= i_rx_dat;
    if (hdr_ld) begin
      sel <= (hdr.cmd_hdr.cmd == acc_cmd_pkg::CMD_FOLD) ? acc_core_pkg::ENG_FOLD
                                                        : acc_core_pkg::ENG_MASK;
      len <= hdr.cmd_hdr.len;
      tag <= hdr.cmd_hdr.tag;
      arg <= hdr.cmd_hdr.arg;
    end
  end

  always_ff @(posedge i_clk_100) begin
    if (!i_rst_n) begin
      rx_val    <= 1'b0;
      state     <= ST_IDLE;
      wcnt      <= 8'd0;
      ccnt      <= 16'd0;
      o_job.val <= 1'b0;
      o_dir.val <= 1'b0;
      o_usr_rst <= 1'b0;
    end else begin
      rx_val    <= i_rx_val;
      state     <= state_nxt;
      wcnt      <= wcnt_nxt;
      ccnt      <= ccnt_nxt;
      o_job     <= job_nxt;
      o_dir     <= dir_nxt;
      o_usr_rst <= rst_nxt;
    end
  end

  // User reset is a single-cycle pulse
  a_usr_rst_pulse: assert property (@(posedge i_clk_100) disable iff (!i_rst_n)
    o_usr_rst |=> !o_usr_rst);

  // A word becomes either a job or a reply, never both
  a_job_dir_excl: assert property (@(posedge i_clk_100) disable iff (!i_rst_n)
    !(o_job.val && o_dir.val));

endmodule

// ==== fold_check_exec.sv ====
/*
  Fold checker. Adds the 32-bit halves of each payload word into a running
  sum and compares the final sum with the header target.
*/
module fold_check_exec (
  input  logic                    i_clk_100,
  input  logic                    i_rst_n,
  input  acc_core_pkg::job_word_t i_job,
  output acc_core_pkg::rpl_req_t  o_res
);

  logic        match;
  logic [31:0] sum;     // Stage one running sum
  logic [31:0] s1_arg;
  logic [15:0] s1_tag;
  logic        s1_done; // Sum is final, compare next cycle

  assign match = i_job.val && (i_job.sel == acc_core_pkg::ENG_FOLD);

  // Stage one, accumulate halves, restart on first word
  always_ff @(posedge i_clk_100) begin
    if (match) begin
      sum    <= (i_job.first ? 32'd0 : sum) + i_job.dat[63:32] + i_job.dat[31:0];
      s1_arg <= i_job.arg;
      s1_tag <= i_job.tag;
    end
  end

  always_ff @(posedge i_clk_100) begin
    if (!i_rst_n) begin
      s1_done   <= 1'b0;
      o_res.val <= 1'b0;
    end else begin
      s1_done   <= match && i_job.last;
      o_res.val <= s1_done;
    end
  end

  // Stage two, compare and build the reply; next frame may already fill stage one
  always_ff @(posedge i_clk_100) begin
    if (s1_done) begin
      o_res.rpl  <= acc_cmd_pkg::RPL_FOLD;
      o_res.sts  <= (sum == s1_arg) ? acc_cmd_pkg::STS_OK : acc_cmd_pkg::STS_FAIL;
      o_res.tag  <= s1_tag;
      o_res.data <= sum;
    end
  end

  // Result only follows a last fold word by exactly the execute latency
  a_res_lat: assert property (@(posedge i_clk_100) disable iff (!i_rst_n)
    o_res.val |-> $past(match && i_job.last, acc_core_pkg::EXEC_LAT));

endmodule

// ==== mask_count_exec.sv ====
/*
  Mask counter. Counts set bits per payload word, totals them over the
  frame and checks the total against the header threshold.
*/
module mask_count_exec (
  input  logic                    i_clk_100,
  input  logic                    i_rst_n,
  input  acc_core_pkg::job_word_t i_job,
  output acc_core_pkg::rpl_req_t  o_res
);

  logic        match;
  logic [6:0]  pc1;            // Set bits of one word, 0 to 64
  logic        s1_val, s1_first, s1_last;
  logic [31:0] s1_arg;
  logic [15:0] s1_tag;
  logic [31:0] acc, acc_sum;   // Frame total so far

  function automatic logic [6:0] popcnt(input acc_cmd_pkg::word_t w);
    logic [6:0] n;
    n = 7'd0;
    for (int i = 0; i < 64; i++) begin
      n = n + {6'd0, w[i]};
    end
    return n;
  endfunction

  assign match   = i_job.val && (i_job.sel == acc_core_pkg::ENG_MASK);
  assign acc_sum = (s1_first ? 32'd0 : acc) + {25'd0, pc1};

  // Stage one, per-word count with flags
  always_ff @(posedge i_clk_100) begin
    pc1      <= popcnt(i_job.dat);
    s1_first <= i_job.first;
    s1_last  <= i_job.last;
    s1_arg   <= i_job.arg;
    s1_tag   <= i_job.tag;
  end

  always_ff @(posedge i_clk_100) begin
    if (!i_rst_n) begin
      s1_val    <= 1'b0;
      o_res.val <= 1'b0;
    end else begin
      s1_val    <= match;
      o_res.val <= s1_val && s1_last;
    end
  end

  // Stage two, running total and threshold compare
  always_ff @(posedge i_clk_100) begin
    if (s1_val) begin
      acc <= acc_sum;
    end
    if (s1_val && s1_last) begin
      o_res.rpl  <= acc_cmd_pkg::RPL_MASK;
      o_res.sts  <= (acc_sum >= s1_arg) ? acc_cmd_pkg::STS_OK : acc_cmd_pkg::STS_FAIL;
      o_res.tag  <= s1_tag;
      o_res.data <= acc_sum;
    end
  end

endmodule

// ==== result_merge.sv ====
/*
  Reply merge. Delays direct decoder replies to line up with engine results,
  picks the one valid source and registers it as a reply word for transmit.
*/
module result_merge (
  input  logic                   i_clk_100,
  input  logic                   i_rst_n,
  input  acc_core_pkg::rpl_req_t i_dir,
  input  acc_core_pkg::rpl_req_t i_fold,
  input  acc_core_pkg::rpl_req_t i_mask,
  output logic                   o_tx_val,
  output acc_cmd_pkg::hdr_word_u o_tx_dat
);

  acc_core_pkg::rpl_req_t dir_dly [acc_core_pkg::EXEC_LAT]; // Direct reply delay line
  acc_core_pkg::rpl_req_t dir_al;                           // Aligned with engine results
  acc_core_pkg::rpl_req_t pick;

  assign dir_al = dir_dly[acc_core_pkg::EXEC_LAT-1];

  always_ff @(posedge i_clk_100) begin
    if (!i_rst_n) begin
      for (int i = 0; i < acc_core_pkg::EXEC_LAT; i++) begin
        dir_dly[i].val <= 1'b0;
      end
    end else begin
      dir_dly[0] <= i_dir;
      for (int i = 1; i < acc_core_pkg::EXEC_LAT; i++) begin
        dir_dly[i] <= dir_dly[i-1];
      end
    end
  end

  // Sources never collide, so priority order is arbitrary
  always_comb begin
    if (dir_al.val) begin
      pick = dir_al;
    end else if (i_fold.val) begin
      pick = i_fold;
    end else begin
      pick = i_mask;
    end
  end

  always_ff @(posedge i_clk_100) begin
    if (!i_rst_n) begin
      o_tx_val <= 1'b0;
    end else begin
      o_tx_val <= pick.val;
    end
  end

  // Pack into the reply view of the header word
  always_ff @(posedge i_clk_100) begin
    o_tx_dat.rpl_hdr.rpl  <= pick.rpl;
    o_tx_dat.rpl_hdr.sts  <= pick.sts;
    o_tx_dat.rpl_hdr.tag  <= pick.tag;
    o_tx_dat.rpl_hdr.data <= pick.data;
  end

  // Frames end at most once per cycle, so one reply source at a time
  a_one_src: assert property (@(posedge i_clk_100) disable iff (!i_rst_n)
    $onehot0({dir_al.val, i_fold.val, i_mask.val}));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass message
verilator --binary --assert -Wno-fatal --top-module tb_acc_engine -f acc_engine.f \
  --Mdir obj_dir -o tb_acc_engine > build.log 2>&1 \
  && ./obj_dir/tb_acc_engine > sim.log 2>&1 \
  && grep -qF '*** PASSED ***' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== tb_acc_engine.sv ====
/*
  Testbench for the command engine. Sends framed commands on the receive port,
  predicts every reply with a reference model and checks it at its due cycle.
*/
module tb_acc_engine;

  logic                   clk_100 = 1'b0;
  logic                   rst_n;
  logic                   rx_val, rx_sop, rx_eop;
  acc_cmd_pkg::word_t     rx_dat;
  logic                   tx_val, usr_rst;
  acc_cmd_pkg::hdr_word_u tx_dat;

  integer                 seed = 32'hcb550eaf;
  int                     cyc = 0;           // Rising edges so far
  int                     errors = 0;
  int                     checks = 0;
  logic [15:0]            ref_ccnt = 16'd0;  // Model of the command counter
  acc_cmd_pkg::word_t     frm_dat[$];        // Frame being built, header first
  logic                   frm_eop[$];
  acc_cmd_pkg::hdr_word_u exp_q[$];          // Expected replies, frame order
  int                     due_q[$];          // Cycle each reply is due
  int                     rst_q[$];          // Cycles with user reset high

  always #50 clk_100 = ~clk_100;
  always @(posedge clk_100) cyc <= cyc + 1;

  acc_engine_top i_dut (
    .i_clk_100 (clk_100),
    .i_rst_n   (rst_n),
    .i_rx_val  (rx_val),
    .i_rx_sop  (rx_sop),
    .i_rx_eop  (rx_eop),
    .i_rx_dat  (rx_dat),
    .o_tx_val  (tx_val),
    .o_tx_dat  (tx_dat),
    .o_usr_rst (usr_rst)
  );

  function automatic int rand_int(input int lo, input int hi);
    return lo + (($random(seed) & 32'h7fffffff) % (hi - lo + 1));
  endfunction

  // Expected reply of the recorded frame, trig is the word that decides it
  function automatic logic ref_reply(output acc_cmd_pkg::hdr_word_u exp, output int trig,
                                     output logic rst);
    acc_cmd_pkg::cmd_hdr_t h;
    logic [31:0]           sum;
    logic [31:0]           ones;
    h    = frm_dat[0];
    exp  = '0;
    trig = 0;
    rst  = 1'b0;
    sum  = 32'd0;
    ones = 32'd0;
    exp.rpl_hdr.tag = h.tag;
    exp.rpl_hdr.rpl = acc_cmd_pkg::RPL_ERR;    // Errors keep data 0
    case (h.cmd)
      acc_cmd_pkg::CMD_STATUS, acc_cmd_pkg::CMD_USR_RST: begin
        if (!frm_eop[0]) begin
          exp.rpl_hdr.sts = acc_cmd_pkg::STS_BAD_FRAME;
          return 1'b1;
        end
        if (h.cmd == acc_cmd_pkg::CMD_USR_RST) begin
          rst      = 1'b1;                     // Silent, clears the counter
          ref_ccnt = 16'd0;
          return 1'b0;
        end
        exp.rpl_hdr.rpl  = acc_cmd_pkg::RPL_STATUS;
        exp.rpl_hdr.data = {acc_cmd_pkg::VERSION, ref_ccnt};
        ref_ccnt++;
        return 1'b1;
      end
      acc_cmd_pkg::CMD_FOLD, acc_cmd_pkg::CMD_MASK: begin
        if (h.len == 8'd0 || frm_eop[0]) begin
          exp.rpl_hdr.sts = acc_cmd_pkg::STS_BAD_LEN;
          return 1'b1;
        end
        for (int i = 1; i <= int'(h.len); i++) begin
          trig = i;
          if (frm_eop[i] != (i == int'(h.len))) begin // Early or missing eop
            exp.rpl_hdr.sts = acc_cmd_pkg::STS_BAD_FRAME;
            return 1'b1;
          end
          sum  += frm_dat[i][63:32] + frm_dat[i][31:0];
          ones += 32'($countones(frm_dat[i]));
        end
        ref_ccnt++;
        if (h.cmd == acc_cmd_pkg::CMD_FOLD) begin
          exp.rpl_hdr.rpl  = acc_cmd_pkg::RPL_FOLD;
          exp.rpl_hdr.data = sum;
          exp.rpl_hdr.sts  = (sum == h.arg) ? acc_cmd_pkg::STS_OK : acc_cmd_pkg::STS_FAIL;
        end else begin
          exp.rpl_hdr.rpl  = acc_cmd_pkg::RPL_MASK;
          exp.rpl_hdr.data = ones;
          exp.rpl_hdr.sts  = (ones >= h.arg) ? acc_cmd_pkg::STS_OK : acc_cmd_pkg::STS_FAIL;
        end
        return 1'b1;
      end
      default: begin
        exp.rpl_hdr.sts = acc_cmd_pkg::STS_BAD_CMD;
        return 1'b1;
      end
    endcase
  endfunction

  task automatic check_rpl(input acc_cmd_pkg::hdr_word_u act,
                           input acc_cmd_pkg::hdr_word_u exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED o_tx_dat at cycle %0d: got %h expected %h", cyc, act, exp);
    end
  endtask

  task automatic check_usr_rst(input logic act, input logic exp);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED o_usr_rst at cycle %0d: got %h expected %h", cyc, act, exp);
    end
  endtask

  // Outputs only move on the rising edge, so look at them on the falling one
  always @(negedge clk_100) begin
    if (rst_n) begin
      if (tx_val) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Reply at cycle %0d while no reply was expected", cyc);
        end else begin
          if (due_q[0] != cyc) begin
            errors++;
            $display("Reply at cycle %0d was due at cycle %0d", cyc, due_q[0]);
          end
          check_rpl(tx_dat, exp_q.pop_front());
          void'(due_q.pop_front());
        end
      end else if (due_q.size() > 0 && due_q[0] <= cyc) begin
        errors++;
        $display("No reply at cycle %0d although one was due", cyc);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
      check_usr_rst(usr_rst, rst_q.size() > 0 && rst_q[0] == cyc);
      if (rst_q.size() > 0 && rst_q[0] <= cyc) void'(rst_q.pop_front());
    end
  end

  // Every input change happens on the falling edge
  task automatic drive(input logic val, input logic sop, input logic eop,
                       input acc_cmd_pkg::word_t d);
    @(negedge clk_100);
    rx_val = val;
    rx_sop = sop;
    rx_eop = eop;
    rx_dat = d;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive(1'b0, 1'(rand_int(0, 1)), 1'(rand_int(0, 1)), {$random(seed), $random(seed)});
  endtask

  // Valid words without sop outside a frame
  task automatic stray_words(input int n);
    repeat (n) drive(1'b1, 1'b0, 1'(rand_int(0, 1)), {$random(seed), $random(seed)});
  endtask

  task automatic new_frame(input logic [7:0] cmd, input logic [7:0] len, input logic eop,
                           input logic [31:0] arg);
    acc_cmd_pkg::cmd_hdr_t h;
    h = {cmd, len, 16'($random(seed)), arg};
    frm_dat.delete();
    frm_eop.delete();
    frm_dat.push_back(h);
    frm_eop.push_back(eop);
  endtask

  // Sends the built frame and queues what the DUT must answer
  task automatic send_frame(input int max_gap);
    acc_cmd_pkg::hdr_word_u exp;
    int                     trig;
    logic                   rst;
    int                     at[$];
    for (int i = 0; i < frm_dat.size(); i++) begin
      if (i > 0) idle_cycles(rand_int(0, max_gap));
      drive(1'b1, i == 0, frm_eop[i], frm_dat[i]);
      at.push_back(cyc + 1);                   // Edge that samples this word
    end
    if (ref_reply(exp, trig, rst)) begin
      exp_q.push_back(exp);
      due_q.push_back(at[trig] + 4);
    end
    if (rst) rst_q.push_back(at[0] + 1);
  endtask

  task automatic simple_frame(input logic [7:0] cmd);
    new_frame(cmd, 8'd0, 1'b1, 32'($random(seed)));
    send_frame(0);
  endtask

  // Any len and eop placement, used for malformed frames
  task automatic raw_frame(input logic [7:0] cmd, input int len, input int words,
                           input int eop_at, input int max_gap);
    new_frame(cmd, 8'(len), eop_at == 0, 32'($random(seed)));
    for (int i = 1; i <= words; i++) begin
      frm_dat.push_back({$random(seed), $random(seed)});
      frm_eop.push_back(i == eop_at);
    end
    send_frame(max_gap);
  endtask

  // Target is the true sum on a hit, some other value on a miss
  task automatic fold_frame(input int len, input logic hit, input int max_gap);
    acc_cmd_pkg::word_t w;
    logic [31:0]        sum;
    logic [31:0]        arg;
    sum = 32'd0;
    new_frame(acc_cmd_pkg::CMD_FOLD, 8'(len), 1'b0, 32'd0);
    for (int i = 1; i <= len; i++) begin
      w   = {$random(seed), $random(seed)};
      sum = sum + w[63:32] + w[31:0];
      frm_dat.push_back(w);
      frm_eop.push_back(i == len);
    end
    arg        = hit ? sum : sum + 32'(rand_int(1, 1000));
    frm_dat[0] = {frm_dat[0][63:32], arg};
    send_frame(max_gap);
  endtask

  // Threshold below (0), equal to (1) or above (2) the set-bit count
  task automatic mask_frame(input int len, input int mode, input int max_gap);
    acc_cmd_pkg::word_t w;
    logic [31:0]        ones;
    logic [31:0]        arg;
    ones = 32'd0;
    new_frame(acc_cmd_pkg::CMD_MASK, 8'(len), 1'b0, 32'd0);
    for (int i = 1; i <= len; i++) begin
      w = {$random(seed), $random(seed)};
      if (rand_int(0, 5) == 0) w = '1;         // Full word now and then
      ones = ones + 32'($countones(w));
      frm_dat.push_back(w);
      frm_eop.push_back(i == len);
    end
    case (mode)
      0:       arg = ones / 2;
      1:       arg = ones;
      default: arg = ones + 32'(rand_int(1, 8));
    endcase
    frm_dat[0] = {frm_dat[0][63:32], arg};
    send_frame(max_gap);
  endtask

  task automatic random_mix(input int n);
    int kind;
    for (int k = 0; k < n; k++) begin
      idle_cycles(rand_int(0, 1) * rand_int(0, 2));  // Often back to back
      kind = rand_int(0, 7);
      case (kind)
        0: simple_frame(acc_cmd_pkg::CMD_STATUS);
        1: begin
          simple_frame(acc_cmd_pkg::CMD_USR_RST);
          idle_cycles(1);                      // Keeps reset pulses apart
        end
        2, 3:    fold_frame(rand_int(1, 6), 1'(rand_int(0, 1)), rand_int(0, 2));
        4, 5:    mask_frame(rand_int(1, 6), rand_int(0, 2), rand_int(0, 2));
        6:       raw_frame(8'h7e, rand_int(0, 3), 2, 2, 1);
        default: raw_frame(acc_cmd_pkg::CMD_FOLD, 3, 2, 2, 0);
      endcase
    end
  endtask

  // Idle until every expected reply and pulse has been seen
  task automatic drain();
    int waited;
    waited = 0;
    while ((exp_q.size() > 0 || rst_q.size() > 0) && waited < 50) begin
      idle_cycles(1);
      waited++;
    end
    if (exp_q.size() > 0 || rst_q.size() > 0) begin
      errors++;
      $display("Timed out with %0d replies still outstanding", exp_q.size());
    end
    idle_cycles(8);                            // Quiet tail catches extra replies
  endtask

  initial begin
    rst_n  = 1'b0;
    rx_val = 1'b0;
    rx_sop = 1'b0;
    rx_eop = 1'b0;
    rx_dat = '0;
    repeat (5) @(negedge clk_100);
    rst_n = 1'b1;

    // Quiet bus, then stray words outside any frame
    idle_cycles(4);
    stray_words(8);
    idle_cycles(6);

    // Counter of earlier commands, cleared by user reset
    simple_frame(acc_cmd_pkg::CMD_STATUS);
    simple_frame(acc_cmd_pkg::CMD_STATUS);
    fold_frame(2, 1'b1, 0);
    simple_frame(acc_cmd_pkg::CMD_STATUS);
    simple_frame(acc_cmd_pkg::CMD_USR_RST);
    simple_frame(acc_cmd_pkg::CMD_STATUS);
    idle_cycles(3);

    for (int k = 0; k < 12; k++) begin
      fold_frame(rand_int(1, 8), 1'(k % 2), rand_int(0, 2));
    end
    fold_frame(20, 1'b1, 1);
    for (int k = 0; k < 12; k++) begin
      mask_frame(rand_int(1, 8), k % 3, rand_int(0, 2));
    end

    // Malformed frames, each followed by a good one
    raw_frame(8'h55, 2, 3, 3, 1);              // Unknown cmd with words
    simple_frame(acc_cmd_pkg::CMD_STATUS);
    raw_frame(8'h33, 0, 0, 0, 0);              // Unknown cmd alone
    fold_frame(2, 1'b0, 0);
    raw_frame(acc_cmd_pkg::CMD_FOLD, 0, 2, 2, 1);
    mask_frame(3, 1, 0);
    raw_frame(acc_cmd_pkg::CMD_MASK, 0, 0, 0, 0);
    raw_frame(acc_cmd_pkg::CMD_MASK, 3, 0, 0, 0);
    fold_frame(1, 1'b1, 0);
    raw_frame(acc_cmd_pkg::CMD_FOLD, 4, 2, 2, 1); // Early eop
    mask_frame(2, 0, 0);
    raw_frame(acc_cmd_pkg::CMD_MASK, 2, 4, 4, 1); // No eop on last word
    simple_frame(acc_cmd_pkg::CMD_STATUS);
    raw_frame(acc_cmd_pkg::CMD_STATUS, 0, 2, 2, 0);
    raw_frame(acc_cmd_pkg::CMD_USR_RST, 0, 1, 1, 0);
    simple_frame(acc_cmd_pkg::CMD_STATUS);
    idle_cycles(3);

    random_mix(150);
    drain();

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
